//--- rtl/daq_ctrl_pkg.sv
package daq_ctrl_pkg;

	// register and address widths of both control banks
	localparam int REG_W  = 7;
	localparam int ADDR_W = 5;

	typedef logic [REG_W-1:0]  reg_word_t;
	typedef logic [ADDR_W-1:0] reg_addr_t;

	// readback word, marker bit flags data to the host
	typedef struct packed {
		logic      marker;
		reg_word_t data;
	} tx_word_t;

	// one write into a bank
	typedef struct packed {
		logic      strobe;
		reg_addr_t addr;
		reg_word_t data;
	} bank_write_t;

	// reserved commands, bits 6 and 5 clear
	typedef enum logic [4:0] {
		OP_FULL_RESET  = 5'd0,
		OP_P1_DELAY    = 5'd1,
		OP_P2_DELAY    = 5'd2,
		OP_P3_DELAY    = 5'd3,
		OP_IDELAY_RST  = 5'd4,
		OP_IDELAY_TRIG = 5'd5,
		OP_TRIM_DAC    = 5'd6
	} trig_op_t;

	// single cycle trigger outputs
	typedef struct packed {
		logic       full_reset;
		// one bit per pickup
		logic [2:0] delay_trig;
		logic       idelay_rst;
		logic       idelay_trig;
		logic       trim_dac_trig;
	} trig_pulses_t;

	// where data bytes go
	typedef enum logic [1:0] {
		ST_BANK_FAST,
		ST_BANK_SLOW,
		ST_RAM
	} dec_state_t;

	// readback link to the uart transmitter
	typedef struct packed {
		logic     word_ready;
		tx_word_t word;
		logic     complete;
	} rb_link_t;

	// fast bank fields after unpacking
	typedef struct packed {
		reg_word_t        trig_delay;
		reg_word_t        trig_out_delay;
		logic             trig_out_en;
		// p1 b1..b3, p2 b1..b3, p3 b1..b3
		logic [8:0][7:0]  bunch_pos;
		// k1/k2 fb, k1/k2 delay loop, k1/k2 const dac enable
		logic [5:0]       fb_flags;
		logic [1:0][12:0] const_dac;
		logic             edge_sel;
		reg_word_t        sample_hold_off;
		logic [11:0]      big_trig_delay;
		reg_word_t        trig_out_delay2;
	} timing_ctrl_t;

	// fast bank map covers registers 0 to 30
	function automatic timing_ctrl_t unpack_timing(input reg_word_t [30:0] regs);
		timing_ctrl_t t;
		t.trig_delay     = regs[0];
		t.trig_out_delay = regs[1];
		t.trig_out_en    = |regs[2];
		// bunch position msb lives in bit 0 of the even register above
		for (int k = 0; k < 9; k++) begin
			t.bunch_pos[k] = {regs[4 + 2 * k][0], regs[3 + 2 * k]};
		end
		t.fb_flags = regs[21][5:0];
		// 13 bit dac words split 6 over 7
		for (int k = 0; k < 2; k++) begin
			t.const_dac[k] = {regs[23 + 2 * k][5:0], regs[22 + 2 * k]};
		end
		t.edge_sel        = |regs[26];
		t.sample_hold_off = regs[27];
		t.big_trig_delay  = {regs[29][4:0], regs[28]};
		t.trig_out_delay2 = regs[30];
		return t;
	endfunction

endpackage

//--- rtl/cmd_decoder.sv
module cmd_decoder (
	input  logic                       tx_clk,
	input  logic                       rst,
	input  logic [7:0]                 byte_in,
	input  logic                       byte_ready,
	output logic                       byte_unload,
	output daq_ctrl_pkg::bank_write_t  wr_fast,
	output daq_ctrl_pkg::bank_write_t  wr_slow,
	output daq_ctrl_pkg::trig_pulses_t pulses
);
	import daq_ctrl_pkg::*;

	// current data target
	dec_state_t state;

	// current address of each bank
	reg_addr_t addr_fast;
	reg_addr_t addr_slow;

	// reserved command code
	trig_op_t op;

	// host has dropped ready after we raised unload
	logic decode;

	assign decode = !byte_ready && byte_unload;
	assign op     = trig_op_t'(byte_in[4:0]);

	always_ff @(posedge tx_clk or posedge rst) begin
		if (rst) begin
			state       <= ST_BANK_FAST;
			addr_fast   <= '0;
			addr_slow   <= '0;
			byte_unload <= 1'b0;
			wr_fast     <= '0;
			wr_slow     <= '0;
			pulses      <= '0;
		end else begin
			// strobes and triggers last one cycle
			wr_fast.strobe <= 1'b0;
			wr_slow.strobe <= 1'b0;
			pulses         <= '0;

			if (byte_ready && !byte_unload) begin
				// byte waiting, take it
				byte_unload <= 1'b1;
			end else if (decode) begin
				byte_unload <= 1'b0;
				if (byte_in[7]) begin
					// data byte, route by target
					case (state)
						ST_BANK_FAST: begin
							wr_fast <= '{strobe: 1'b1, addr: addr_fast, data: byte_in[6:0]};
						end
						ST_BANK_SLOW: begin
							wr_slow <= '{strobe: 1'b1, addr: addr_slow, data: byte_in[6:0]};
						end
						default: begin
							// ram fill not present
						end
					endcase
				end else if (byte_in[6]) begin
					// register address command
					if (byte_in[5]) begin
						state     <= ST_BANK_SLOW;
						addr_slow <= byte_in[4:0];
					end else begin
						state     <= ST_BANK_FAST;
						addr_fast <= byte_in[4:0];
					end
				end else if (byte_in[5]) begin
					// ram select, data dropped until next address
					state <= ST_RAM;
				end else begin
					// reserved commands
					case (op)
						OP_FULL_RESET: begin
							pulses.full_reset <= 1'b1;
						end
						OP_P1_DELAY: begin
							pulses.delay_trig[0] <= 1'b1;
						end
						OP_P2_DELAY: begin
							pulses.delay_trig[1] <= 1'b1;
						end
						OP_P3_DELAY: begin
							pulses.delay_trig[2] <= 1'b1;
						end
						OP_IDELAY_RST: begin
							pulses.idelay_rst <= 1'b1;
						end
						OP_IDELAY_TRIG: begin
							pulses.idelay_trig <= 1'b1;
						end
						OP_TRIM_DAC: begin
							pulses.trim_dac_trig <= 1'b1;
						end
						default: begin
							// framing codes and xon/xoff, nothing to do
						end
					endcase
				end
			end
		end
	end

	// one trigger per decoded byte
	a_single_pulse: assert property (
		@(posedge tx_clk) disable iff (rst)
		$onehot0(pulses)
	);

	// a write needs a full byte handshake, so never back to back
	a_strobe_gap: assert property (
		@(posedge tx_clk) disable iff (rst)
		(wr_fast.strobe || wr_slow.strobe) |=> !(wr_fast.strobe || wr_slow.strobe)
	);

endmodule

//--- rtl/ctrl_reg_bank.sv
module ctrl_reg_bank #(
	parameter int N_REGS = 31
) (
	input  logic                                   tx_clk,
	input  logic                                   rst,
	input  daq_ctrl_pkg::bank_write_t              wr,
	input  daq_ctrl_pkg::reg_addr_t                rd_addr,
	output daq_ctrl_pkg::reg_word_t                rd_data,
	output daq_ctrl_pkg::reg_word_t [N_REGS-1:0]   regs
);

	// address is inside this bank
	logic wr_in_range;
	logic rd_in_range;

	assign wr_in_range = wr.addr < N_REGS;
	assign rd_in_range = rd_addr < N_REGS;

	// register storage
	// cleared so every control field starts at zero
	always_ff @(posedge tx_clk or posedge rst) begin
		if (rst) begin
			regs <= '0;
		end else if (wr.strobe && wr_in_range) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// readback port
	// readback counter runs one past the last register
	always_comb begin
		if (rd_in_range) begin
			rd_data = regs[rd_addr];
		end else begin
			rd_data = '0;
		end
	end

	// host should only address existing registers
	a_wr_addr: assert property (
		@(posedge tx_clk) disable iff (rst)
		wr.strobe |-> wr_in_range
	);

endmodule

//--- rtl/reg_readback.sv
module reg_readback #(
	parameter int N_REGS = 31
) (
	input  logic                    tx_clk,
	input  logic                    rst,
	input  logic                    tx_en,
	input  logic                    word_loaded,
	input  daq_ctrl_pkg::reg_word_t rd_data,
	output daq_ctrl_pkg::reg_addr_t rd_addr,
	output daq_ctrl_pkg::rb_link_t  link
);
	import daq_ctrl_pkg::*;

	// word count, one extra bit to reach N_REGS
	logic [ADDR_W:0] cnt;

	// loaded flag comes from the baud domain
	logic loaded_meta;
	logic loaded_sync;

	logic     word_ready;
	logic     complete;
	tx_word_t word;

	assign rd_addr = cnt[ADDR_W-1:0];
	assign link    = '{word_ready: word_ready, word: word, complete: complete};

	always_ff @(posedge tx_clk or posedge rst) begin
		if (rst) begin
			cnt         <= '0;
			loaded_meta <= 1'b0;
			loaded_sync <= 1'b0;
			word_ready  <= 1'b0;
			complete    <= 1'b0;
		end else begin
			loaded_meta <= word_loaded;
			loaded_sync <= loaded_meta;
			if (!complete) begin
				if (tx_en) begin
					if (!word_ready && !loaded_sync) begin
						// uart idle
						if (cnt == N_REGS) begin
							// last register already sent
							complete <= 1'b1;
						end else begin
							word_ready <= 1'b1;
						end
					end else if (word_ready && loaded_sync) begin
						// uart has taken the word
						word_ready <= 1'b0;
						cnt        <= cnt + 1'b1;
					end
				end
			end else if (!tx_en) begin
				// host done, rearm for next readback
				cnt         <= '0;
				loaded_meta <= 1'b0;
				loaded_sync <= 1'b0;
				word_ready  <= 1'b0;
				complete    <= 1'b0;
			end
		end
	end

	// leading 1 marks a data word
	always_ff @(posedge tx_clk) begin
		word <= '{marker: 1'b1, data: rd_data};
	end

	// count stops at the bank size
	a_cnt_range: assert property (
		@(posedge tx_clk) disable iff (rst)
		cnt <= N_REGS
	);

endmodule

//--- rtl/reset_sequencer.sv
module reset_sequencer #(
	parameter int DCM_HOLD_CYCLES = 8500000,
	parameter int IDELAY_GAP      = 10,
	parameter int IDELAY_PULSE    = 10
) (
	input  logic                       tx_clk,
	input  logic                       rst,
	input  daq_ctrl_pkg::trig_pulses_t pulses,
	output logic                       dcm_rst,
	output logic                       idelay_rst_out
);

	// counter sized for the longest phase
	localparam int MAX_A     = (DCM_HOLD_CYCLES > IDELAY_GAP) ? DCM_HOLD_CYCLES : IDELAY_GAP;
	localparam int MAX_PHASE = (MAX_A > IDELAY_PULSE) ? MAX_A : IDELAY_PULSE;
	localparam int CNT_W     = $clog2(MAX_PHASE + 1);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_DCM,
		SEQ_GAP,
		SEQ_IDELAY
	} seq_state_t;

	seq_state_t       state;
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge tx_clk or posedge rst) begin
		if (rst) begin
			state          <= SEQ_IDLE;
			cnt            <= '0;
			dcm_rst        <= 1'b0;
			idelay_rst_out <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
			case (state)
				SEQ_IDLE: begin
					cnt <= '0;
					// partial reset skips the dcm
					if (pulses.idelay_rst) begin
						state <= SEQ_GAP;
					end else if (pulses.full_reset) begin
						state   <= SEQ_DCM;
						dcm_rst <= 1'b1;
					end
				end
				SEQ_DCM: begin
					// hold while the dcm locks and settles
					if (cnt == CNT_W'(DCM_HOLD_CYCLES - 1)) begin
						state   <= SEQ_GAP;
						dcm_rst <= 1'b0;
						cnt     <= '0;
					end
				end
				SEQ_GAP: begin
					if (cnt == CNT_W'(IDELAY_GAP - 1)) begin
						state          <= SEQ_IDELAY;
						idelay_rst_out <= 1'b1;
						cnt            <= '0;
					end
				end
				default: begin
					// idelayctrl reset pulse
					if (cnt == CNT_W'(IDELAY_PULSE - 1)) begin
						state          <= SEQ_IDLE;
						idelay_rst_out <= 1'b0;
						cnt            <= '0;
					end
				end
			endcase
		end
	end

	// idelayctrl reset only after the dcm is released
	a_no_overlap: assert property (
		@(posedge tx_clk) disable iff (rst)
		!(dcm_rst && idelay_rst_out)
	);

endmodule

//--- rtl/daq_ctrl_top.sv
module daq_ctrl_top #(
	parameter int FAST_REGS       = 31,
	parameter int SLOW_REGS       = 23,
	parameter int DCM_HOLD_CYCLES = 8500000,
	parameter int IDELAY_GAP      = 10,
	parameter int IDELAY_PULSE    = 10
) (
	input  logic                       tx_clk,
	input  logic                       rst,
	input  logic [7:0]                 byte_in,
	input  logic                       byte_ready,
	input  logic                       tx_en_fast,
	input  logic                       tx_en_slow,
	input  logic                       word_loaded_fast,
	input  logic                       word_loaded_slow,
	output logic                       byte_unload,
	output daq_ctrl_pkg::timing_ctrl_t timing,
	output daq_ctrl_pkg::trig_pulses_t pulses,
	output daq_ctrl_pkg::rb_link_t     rb_fast,
	output daq_ctrl_pkg::rb_link_t     rb_slow,
	output logic                       dcm_rst,
	output logic                       idelay_rst_out
);
	import daq_ctrl_pkg::*;

	bank_write_t wr_fast;
	bank_write_t wr_slow;

	// fast bank array feeds the field outputs
	reg_word_t [FAST_REGS-1:0] fast_regs;

	// readback ports
	reg_addr_t fast_rd_addr;
	reg_word_t fast_rd_data;
	reg_addr_t slow_rd_addr;
	reg_word_t slow_rd_data;

	cmd_decoder u_dec (
		.tx_clk      (tx_clk),
		.rst         (rst),
		.byte_in     (byte_in),
		.byte_ready  (byte_ready),
		.byte_unload (byte_unload),
		.wr_fast     (wr_fast),
		.wr_slow     (wr_slow),
		.pulses      (pulses)
	);

	// fast timing bank
	ctrl_reg_bank #(.N_REGS(FAST_REGS)) u_fast_bank (
		.tx_clk  (tx_clk),
		.rst     (rst),
		.wr      (wr_fast),
		.rd_addr (fast_rd_addr),
		.rd_data (fast_rd_data),
		.regs    (fast_regs)
	);

	// slow bank, seen only through readback
	ctrl_reg_bank #(.N_REGS(SLOW_REGS)) u_slow_bank (
		.tx_clk  (tx_clk),
		.rst     (rst),
		.wr      (wr_slow),
		.rd_addr (slow_rd_addr),
		.rd_data (slow_rd_data),
		.regs    ()
	);

	reg_readback #(.N_REGS(FAST_REGS)) u_fast_rb (
		.tx_clk      (tx_clk),
		.rst         (rst),
		.tx_en       (tx_en_fast),
		.word_loaded (word_loaded_fast),
		.rd_data     (fast_rd_data),
		.rd_addr     (fast_rd_addr),
		.link        (rb_fast)
	);

	reg_readback #(.N_REGS(SLOW_REGS)) u_slow_rb (
		.tx_clk      (tx_clk),
		.rst         (rst),
		.tx_en       (tx_en_slow),
		.word_loaded (word_loaded_slow),
		.rd_data     (slow_rd_data),
		.rd_addr     (slow_rd_addr),
		.link        (rb_slow)
	);

	// dcm then idelayctrl reset
	reset_sequencer #(
		.DCM_HOLD_CYCLES (DCM_HOLD_CYCLES),
		.IDELAY_GAP      (IDELAY_GAP),
		.IDELAY_PULSE    (IDELAY_PULSE)
	) u_rst_seq (
		.tx_clk         (tx_clk),
		.rst            (rst),
		.pulses         (pulses),
		.dcm_rst        (dcm_rst),
		.idelay_rst_out (idelay_rst_out)
	);

	// named timing fields straight from the bank
	assign timing = unpack_timing(fast_regs);

endmodule

//--- bench/tb_daq_ctrl.sv
module tb_daq_ctrl;
	timeunit 1ns;
	timeprecision 1ps;

	import daq_ctrl_pkg::*;

	localparam int FAST_REGS = 31;
	localparam int SLOW_REGS = 23;

	// one line of the case file
	typedef struct packed {
		logic [7:0] op;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] d;
	} case_t;

	logic         tx_clk;
	logic         rst;
	logic [7:0]   byte_in;
	logic         byte_ready;
	logic         tx_en_fast;
	logic         tx_en_slow;
	logic         word_loaded_fast;
	logic         word_loaded_slow;
	logic         byte_unload;
	timing_ctrl_t timing;
	trig_pulses_t pulses;
	rb_link_t     rb_fast;
	rb_link_t     rb_slow;
	logic         dcm_rst;
	logic         idelay_rst_out;

	case_t     cases[$];
	// expected contents with the fast bank in row 0 and the slow bank in row 1
	reg_word_t model[2][FAST_REGS];
	int        errors;
	bit        cases_ready;

	daq_ctrl_top #(
		.FAST_REGS       (FAST_REGS),
		.SLOW_REGS       (SLOW_REGS),
		.DCM_HOLD_CYCLES (20),
		.IDELAY_GAP      (4),
		.IDELAY_PULSE    (3)
	) dut_i (
		.tx_clk           (tx_clk),
		.rst              (rst),
		.byte_in          (byte_in),
		.byte_ready       (byte_ready),
		.tx_en_fast       (tx_en_fast),
		.tx_en_slow       (tx_en_slow),
		.word_loaded_fast (word_loaded_fast),
		.word_loaded_slow (word_loaded_slow),
		.byte_unload      (byte_unload),
		.timing           (timing),
		.pulses           (pulses),
		.rb_fast          (rb_fast),
		.rb_slow          (rb_slow),
		.dcm_rst          (dcm_rst),
		.idelay_rst_out   (idelay_rst_out)
	);

	always #50 tx_clk = ~tx_clk;

	task automatic report_mismatch(input string name, input logic [159:0] got,
			input logic [159:0] exp);
		errors++;
		$display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("ERROR %s", msg);
	endtask

	// fast bank field map built from the model
	function automatic timing_ctrl_t expected_timing();
		timing_ctrl_t e;
		e.trig_delay     = model[0][0];
		e.trig_out_delay = model[0][1];
		e.trig_out_en    = model[0][2] != 0;
		for (int k = 0; k < 9; k++) begin
			// low bits from the odd register and msb from bit 0 of the next
			e.bunch_pos[k][6:0] = model[0][3 + 2 * k];
			e.bunch_pos[k][7]   = model[0][4 + 2 * k][0];
		end
		e.fb_flags = model[0][21][5:0];
		for (int k = 0; k < 2; k++) begin
			e.const_dac[k][6:0]  = model[0][22 + 2 * k];
			e.const_dac[k][12:7] = model[0][23 + 2 * k][5:0];
		end
		e.edge_sel             = model[0][26] != 0;
		e.sample_hold_off      = model[0][27];
		e.big_trig_delay[6:0]  = model[0][28];
		e.big_trig_delay[11:7] = model[0][29][4:0];
		e.trig_out_delay2      = model[0][30];
		return e;
	endfunction

	task automatic check_timing();
		timing_ctrl_t exp;
		exp = expected_timing();
		assert (timing == exp) else report_mismatch("timing", 160'(timing), 160'(exp));
	endtask

	function automatic rb_link_t link_of(input int bank);
		return (bank == 1) ? rb_slow : rb_fast;
	endfunction

	task automatic drive_tx_en(input int bank, input logic v);
		if (bank == 1) begin
			tx_en_slow = v;
		end else begin
			tx_en_fast = v;
		end
	endtask

	task automatic drive_loaded(input int bank, input logic v);
		if (bank == 1) begin
			word_loaded_slow = v;
		end else begin
			word_loaded_fast = v;
		end
	endtask

	// host uart side of the ready/unload handshake
	// returns on the falling edge after the decode edge
	task automatic send_byte(input logic [7:0] b);
		int extra;
		extra = $urandom % 3;
		@(negedge tx_clk);
		byte_in    = b;
		byte_ready = 1'b1;
		@(negedge tx_clk);
		while (!byte_unload) begin
			@(negedge tx_clk);
		end
		// host may hold ready a while and nothing decodes meanwhile
		repeat (extra) @(negedge tx_clk);
		byte_ready = 1'b0;
		@(negedge tx_clk);
		assert (!byte_unload) else report_mismatch("byte_unload", 160'(byte_unload), 160'(0));
	endtask

	task automatic write_reg(input int bank, input logic [4:0] addr, input logic [7:0] val);
		reg_word_t d;
		// ff asks for a random value
		d = (val == 8'hff) ? reg_word_t'($urandom) : val[6:0];
		send_byte({2'b01, bank[0], addr});
		send_byte({1'b1, d});
		model[bank][addr] = d;
		@(negedge tx_clk);
		check_timing();
	endtask

	task automatic data_byte(input logic [7:0] b, input int bank, input logic [4:0] addr);
		send_byte(b);
		// bank 2 is a byte that must land nowhere
		if (bank < 2) begin
			model[bank][addr] = b[6:0];
		end
		@(negedge tx_clk);
		check_timing();
	endtask

	task automatic command(input logic [7:0] b, input logic [6:0] mask);
		send_byte(b);
		assert (pulses == mask) else report_mismatch("pulses", 160'(pulses), 160'(mask));
		@(negedge tx_clk);
		// one cycle only
		assert (pulses == '0) else report_mismatch("pulses", 160'(pulses), 160'(0));
		check_timing();
	endtask

	// uart transmitter model that takes each word and stays busy for hold cycles
	task automatic read_bank(input int bank, input int hold);
		int       n_regs;
		int       idx;
		bit       done;
		string    nm;
		rb_link_t lk;
		n_regs = (bank == 1) ? SLOW_REGS : FAST_REGS;
		nm     = (bank == 1) ? "rb_slow" : "rb_fast";
		idx    = 0;
		done   = 1'b0;
		@(negedge tx_clk);
		drive_tx_en(bank, 1'b1);
		while (!done) begin
			@(negedge tx_clk);
			lk = link_of(bank);
			if (lk.complete) begin
				done = 1'b1;
			end else if (lk.word_ready) begin
				assert (idx < n_regs)
				else report_problem($sformatf("%s offered a word past the last register", nm));
				if (idx < n_regs) begin
					assert (lk.word == {1'b1, model[bank][idx]})
					else report_mismatch({nm, ".word"}, 160'(lk.word),
						160'({1'b1, model[bank][idx]}));
				end
				idx++;
				drive_loaded(bank, 1'b1);
				while (lk.word_ready) begin
					@(negedge tx_clk);
					lk = link_of(bank);
				end
				// uart still busy so the engine has to wait
				repeat (hold) begin
					@(negedge tx_clk);
					lk = link_of(bank);
					assert (!lk.word_ready)
					else report_mismatch({nm, ".word_ready"}, 160'(lk.word_ready), 160'(0));
				end
				drive_loaded(bank, 1'b0);
			end
		end
		assert (idx == n_regs)
		else report_problem($sformatf("%s sent %0d words instead of %0d", nm, idx, n_regs));
		drive_tx_en(bank, 1'b0);
		@(negedge tx_clk);
		lk = link_of(bank);
		assert (!lk.complete)
		else report_mismatch({nm, ".complete"}, 160'(lk.complete), 160'(0));
	endtask

	// measures the dcm, gap and idelay phases after a reset command
	task automatic seq_check(input logic [7:0] cmd, input int dcm_len, input int gap_len,
			input int pulse_len);
		int dcm_n;
		int gap_n;
		int pulse_n;
		int guard;
		bit seen;
		bit done;
		dcm_n   = 0;
		gap_n   = 0;
		pulse_n = 0;
		guard   = 0;
		seen    = 1'b0;
		done    = 1'b0;
		// earlier reset commands must have run out
		repeat (40) @(negedge tx_clk);
		send_byte(cmd);
		while (!done && guard < 200) begin
			@(negedge tx_clk);
			guard++;
			if (idelay_rst_out) begin
				pulse_n++;
				seen = 1'b1;
			end else if (seen) begin
				done = 1'b1;
			end else if (dcm_rst) begin
				dcm_n++;
			end else begin
				gap_n++;
			end
		end
		assert (done) else report_problem("idelay reset phase never ended");
		assert (dcm_n == dcm_len) else report_mismatch("dcm_rst", 160'(dcm_n), 160'(dcm_len));
		assert (gap_n == gap_len) else report_mismatch("gap", 160'(gap_n), 160'(gap_len));
		assert (pulse_n == pulse_len)
		else report_mismatch("idelay_rst_out", 160'(pulse_n), 160'(pulse_len));
	endtask

	initial begin
		int               fd;
		int               n;
		logic [7:0]       op;
		logic [7:0]       a;
		logic [7:0]       b;
		logic [7:0]       c;
		logic [7:0]       d;
		logic [8*128-1:0] rest;
		case_t            cs;
		tx_clk           = 1'b0;
		rst              = 1'b1;
		byte_in          = '0;
		byte_ready       = 1'b0;
		tx_en_fast       = 1'b0;
		tx_en_slow       = 1'b0;
		word_loaded_fast = 1'b0;
		word_loaded_slow = 1'b0;
		errors           = 0;
		cases_ready      = 1'b0;
		foreach (model[i, j]) begin
			model[i][j] = '0;
		end
		void'($urandom(55939));

		fd = $fopen("bench/ctrl_cases.txt", "r");
		if (fd == 0) begin
			report_problem("cannot open bench/ctrl_cases.txt");
		end else begin
			while ($fscanf(fd, " %c", op) == 1) begin
				if (op == "#") begin
					void'($fgets(rest, fd));
				end else begin
					n = $fscanf(fd, " %h %h %h %h", a, b, c, d);
					if (n != 4) begin
						report_problem("case line with missing operands");
					end
					cs = {op, a, b, c, d};
					cases.push_back(cs);
				end
			end
			$fclose(fd);
		end
		cases_ready = 1'b1;

		repeat (8) @(posedge tx_clk);
		@(negedge tx_clk);
		rst = 1'b0;
		@(negedge tx_clk);
		assert ({byte_unload, pulses, rb_fast.word_ready, rb_fast.complete, rb_slow.word_ready,
				rb_slow.complete, dcm_rst, idelay_rst_out} == '0)
		else report_problem("control outputs active after reset");
		check_timing();

		foreach (cases[i]) begin
			cs = cases[i];
			case (cs.op)
				"D": data_byte(cs.a, int'(cs.b), cs.c[4:0]);
				"W": write_reg(int'(cs.a), cs.b[4:0], cs.c);
				"C": command(cs.a, cs.b[6:0]);
				"R": read_bank(int'(cs.a), int'(cs.b));
				"S": seq_check(cs.a, int'(cs.b), int'(cs.c), int'(cs.d));
				default: report_problem($sformatf("unknown operation %c in case %0d", cs.op, i));
			endcase
		end

		$display("%0d cases run, %0d errors", cases.size(), errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// budget of 400 cycles per case
	initial begin
		wait (cases_ready);
		repeat ((cases.size() + 1) * 400) @(posedge tx_clk);
		$display("watchdog expired, the run did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- daq_ctrl.f
rtl/daq_ctrl_pkg.sv
rtl/cmd_decoder.sv
rtl/ctrl_reg_bank.sv
rtl/reg_readback.sv
rtl/reset_sequencer.sv
rtl/daq_ctrl_top.sv
bench/tb_daq_ctrl.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_daq_ctrl \
	-f daq_ctrl.f -o sim_daq_ctrl

./obj_dir/sim_daq_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	echo "simulation stopped before the end of the testbench"
	exit 1
fi

//--- bench/ctrl_cases.txt
# op a b c d, all operands hex, unused ones 0
# D: data byte a, expected bank b (2 is none) and address c
# W: write to bank a, address b, data c (ff is a random value)
# C: command byte a, expected pulse bits b for one cycle
# R: readback of bank a, word_loaded held b extra cycles
# S: reset command a, expected dcm_rst, gap and idelay_rst_out cycles
D 85 00 00 00
W 00 01 2a 00
W 00 02 00 00
W 00 03 ff 00
W 00 04 01 00
W 00 13 ff 00
W 00 14 ff 00
W 00 15 3f 00
W 00 16 ff 00
W 00 17 ff 00
W 00 18 ff 00
W 00 19 ff 00
W 00 1a 10 00
W 00 1c ff 00
W 00 1d ff 00
W 00 1e ff 00
W 01 00 ff 00
W 01 05 ff 00
W 01 16 ff 00
W 01 0b 55 00
D bf 01 0b 00
C 00 40 00 00
C 01 08 00 00
C 02 10 00 00
C 03 20 00 00
C 04 04 00 00
C 05 02 00 00
C 06 01 00 00
C 07 00 00 00
C 1f 00 00 00
C 20 00 00 00
D c5 02 00 00
C 3f 00 00 00
D ff 02 00 00
C 42 00 00 00
D 83 00 02 00
C 61 00 00 00
D 9e 01 01 00
R 01 00 00 00
R 01 0c 00 00
R 00 03 00 00
S 00 14 04 03
S 04 00 04 03
